// File: source/frame_avg_pkg.sv
/*
 * Frame averager shared constants.
 * Pixel, image stream and sum stream widths, plus the averaging
 * level range and the frame counter width it needs.
 */

package frame_avg_pkg;

    // image side
    localparam int unsigned PIX_W = 14;    // sensor pixel bits
    localparam int unsigned IMG_W = 16;    // image stream word, pixel in low bits

    // averaging buffer side
    localparam int unsigned SUM_W = 32;    // stored running sum per pixel

    // averaging control
    localparam int unsigned LEVEL_W   = 3;    // run length is 2^level frames
    localparam int unsigned MAX_LEVEL = 7;    // 128 frames per run
    localparam int unsigned CNT_W     = 7;    // frame index, up to 127

endpackage

// File: source/pix_stream_if.sv
/*
 * Pixel stream bundle.
 * AXI4-Stream style data, valid, ready, last and user signals
 * between the blocks of the frame averager.
 */

interface pix_stream_if #(
    parameter int unsigned DW = frame_avg_pkg::SUM_W
);

    logic [DW-1:0] tdata;
    logic          tvalid;
    logic          tready;
    logic          tlast;     // end of line
    logic          tuser;     // start of frame

    modport src (
        output tdata,
        output tvalid,
        input  tready,
        output tlast,
        output tuser
    );

    modport snk (
        input  tdata,
        input  tvalid,
        output tready,
        input  tlast,
        input  tuser
    );

endinterface

// File: source/avg_frame_ctrl.sv
/*
 * Averaging frame control.
 * Counts frames on sof_strb, latches the averaging level at the start
 * of each run, masks the stored sum on the first frame and enables
 * the image output on the last frame of the run.
 */

module avg_frame_ctrl (
    input  logic                              axis_aclk,
    input  logic                              axis_aresetn,
    input  logic                              sof_strb,
    input  logic [frame_avg_pkg::LEVEL_W-1:0] average_level,
    output logic [frame_avg_pkg::LEVEL_W-1:0] avg_level,
    output logic                              sum_keep,
    output logic                              out_en
);
    import frame_avg_pkg::*;

    logic [CNT_W-1:0] frame_cnt;
    logic [CNT_W-1:0] last_cnt;

    // 2^L - 1 where level 7 wraps round to 127
    assign last_cnt = (CNT_W'(1) << avg_level) - CNT_W'(1);

    always_ff @(posedge axis_aclk) begin
        if (!axis_aresetn) begin
            frame_cnt <= '0;
            avg_level <= '0;
            sum_keep  <= 1'b0;
            out_en    <= 1'b0;
        end else if (sof_strb) begin
            if (avg_level != '0) begin
                if (frame_cnt == '0) begin
                    out_en    <= 1'b0;              // first frame of a run
                    sum_keep  <= 1'b0;              // start from a zero sum
                    avg_level <= average_level;
                    frame_cnt <= frame_cnt + 1'b1;
                end else begin
                    sum_keep <= 1'b1;               // accumulate onto stored sum
                    if (frame_cnt == last_cnt) begin
                        out_en    <= 1'b1;          // last frame emits the average
                        frame_cnt <= '0;
                    end else begin
                        out_en    <= 1'b0;
                        frame_cnt <= frame_cnt + 1'b1;
                    end
                end
            end else begin
                avg_level <= average_level;         // pass-through mode
                out_en    <= 1'b1;
                sum_keep  <= 1'b0;
                frame_cnt <= '0;
            end
        end
    end

    // image output only once the count has wrapped at the end of a run
    a_out_en_cnt_zero : assert property (
        @(posedge axis_aclk) disable iff (!axis_aresetn)
        out_en |-> frame_cnt == '0
    ) else $error("out_en high while a run is still counting");

endmodule

// File: source/pix_sum_stage.sv
/*
 * Pixel plus stored sum stage.
 * Joins one image pixel with one stored sum, masks the sum on the
 * first frame of a run and registers the new sum with the pixel's
 * framing bits.
 */

module pix_sum_stage (
    input  logic                            axis_aclk,
    input  logic                            axis_aresetn,
    input  logic                            sum_keep,
    input  logic [frame_avg_pkg::IMG_W-1:0] img_tdata,
    input  logic                            img_tvalid,
    output logic                            img_tready,
    input  logic                            img_tlast,
    input  logic                            img_tuser,
    input  logic [frame_avg_pkg::SUM_W-1:0] avgi_tdata,
    input  logic                            avgi_tvalid,
    output logic                            avgi_tready,
    pix_stream_if.src                       sum_o
);
    import frame_avg_pkg::*;

    logic             stage_free;
    logic             join_beat;
    logic [SUM_W-1:0] stored_sum;

    assign stage_free  = !sum_o.tvalid || sum_o.tready;    // register empty or draining
    assign img_tready  = stage_free && avgi_tvalid;         // take a pixel only with its sum
    assign avgi_tready = stage_free && img_tvalid;
    assign join_beat   = stage_free && img_tvalid && avgi_tvalid;
    assign stored_sum  = sum_keep ? avgi_tdata : '0;       // zero on first frame of run

    always_ff @(posedge axis_aclk) begin
        if (!axis_aresetn) begin
            sum_o.tvalid <= 1'b0;
        end else if (join_beat) begin
            sum_o.tvalid <= 1'b1;
        end else if (sum_o.tready) begin
            sum_o.tvalid <= 1'b0;
        end
    end

    always_ff @(posedge axis_aclk) begin
        if (join_beat) begin
            sum_o.tdata <= SUM_W'(img_tdata[PIX_W-1:0]) + stored_sum;
            sum_o.tlast <= img_tlast;
            sum_o.tuser <= img_tuser;
        end
    end

    // a waiting pixel stays put until it is joined with its sum
    a_img_hold : assert property (
        @(posedge axis_aclk) disable iff (!axis_aresetn)
        img_tvalid && !img_tready |=>
            img_tvalid && $stable(img_tdata) && $stable(img_tlast) && $stable(img_tuser)
    ) else $error("image beat withdrawn or changed before the join");

endmodule

// File: source/sum_fork.sv
/*
 * Sum broadcast.
 * Sends every new sum back to the averaging buffer and, when the
 * frame is the last of a run, the sum scaled by 2^-L to the image
 * output. Each branch may stall on its own.
 */

module sum_fork (
    input  logic                              axis_aclk,
    input  logic                              axis_aresetn,
    input  logic [frame_avg_pkg::LEVEL_W-1:0] avg_level,
    input  logic                              out_en,
    pix_stream_if.snk                         sum_i,
    output logic [frame_avg_pkg::SUM_W-1:0]   avgo_tdata,
    output logic                              avgo_tvalid,
    input  logic                              avgo_tready,
    output logic                              avgo_tlast,
    output logic [frame_avg_pkg::IMG_W-1:0]   img_tdata,
    output logic                              img_tvalid,
    input  logic                              img_tready,
    output logic                              img_tlast,
    output logic                              img_tuser
);
    import frame_avg_pkg::*;

    logic                       avgo_done;    // avgo took the current beat
    logic                       img_done;     // image branch took the current beat
    logic                       avgo_ok;
    logic                       img_ok;
    logic                       in_beat;
    logic [PIX_W+MAX_LEVEL-1:0] sum_win;      // widest sum a full run can reach
    logic [PIX_W+MAX_LEVEL-1:0] sum_scaled;

    assign sum_win    = sum_i.tdata[PIX_W+MAX_LEVEL-1:0];
    assign sum_scaled = sum_win >> avg_level;

    // buffer return branch
    assign avgo_tdata  = sum_i.tdata;
    assign avgo_tlast  = sum_i.tlast;
    assign avgo_tvalid = sum_i.tvalid && !avgo_done;

    // image branch, only on the last frame of a run
    assign img_tdata  = IMG_W'(sum_scaled[PIX_W-1:0]);
    assign img_tlast  = sum_i.tlast;
    assign img_tuser  = sum_i.tuser;
    assign img_tvalid = sum_i.tvalid && out_en && !img_done;

    assign avgo_ok      = avgo_done || avgo_tready;
    assign img_ok       = !out_en || img_done || img_tready;
    assign sum_i.tready = avgo_ok && img_ok;           // release once both branches have it
    assign in_beat      = sum_i.tvalid && sum_i.tready;

    always_ff @(posedge axis_aclk) begin
        if (!axis_aresetn) begin
            avgo_done <= 1'b0;
            img_done  <= 1'b0;
        end else if (in_beat) begin
            avgo_done <= 1'b0;
            img_done  <= 1'b0;
        end else begin
            if (avgo_tvalid && avgo_tready) begin
                avgo_done <= 1'b1;
            end
            if (img_tvalid && img_tready) begin
                img_done <= 1'b1;
            end
        end
    end

    // a pending image beat is never withdrawn by the frame control
    a_img_only_on_out_en : assert property (
        @(posedge axis_aclk) disable iff (!axis_aresetn)
        img_tvalid && !img_tready |=> img_tvalid && out_en
    ) else $error("image beat pending while out_en is low");

endmodule

// File: source/frame_averager_top.sv
/*
 * AXI4-Stream frame averager top.
 * Averages 2^L image frames against a running sum kept in external
 * memory, which is read on avgi and written back on avgo.
 */

module frame_averager_top (
    input  logic                              axis_aclk,
    input  logic                              axis_aresetn,

    input  logic [frame_avg_pkg::LEVEL_W-1:0] average_level,
    input  logic                              sof_strb,

    input  logic [frame_avg_pkg::IMG_W-1:0]   s_axis_img_tdata,
    input  logic                              s_axis_img_tvalid,
    output logic                              s_axis_img_tready,
    input  logic                              s_axis_img_tlast,
    input  logic                              s_axis_img_tuser,

    input  logic [frame_avg_pkg::SUM_W-1:0]   s_axis_avgi_tdata,
    input  logic                              s_axis_avgi_tvalid,
    output logic                              s_axis_avgi_tready,
    input  logic                              s_axis_avgi_tlast,

    output logic [frame_avg_pkg::SUM_W-1:0]   m_axis_avgo_tdata,
    output logic                              m_axis_avgo_tvalid,
    input  logic                              m_axis_avgo_tready,
    output logic                              m_axis_avgo_tlast,

    output logic [frame_avg_pkg::IMG_W-1:0]   m_axis_img_tdata,
    output logic                              m_axis_img_tvalid,
    input  logic                              m_axis_img_tready,
    output logic                              m_axis_img_tlast,
    output logic                              m_axis_img_tuser
);
    import frame_avg_pkg::*;

    logic [LEVEL_W-1:0] avg_level;    // level of the current run
    logic               sum_keep;
    logic               out_en;

    pix_stream_if #(.DW(SUM_W)) sum_s ();

    avg_frame_ctrl avg_frame_ctrl_i (
        .axis_aclk     (axis_aclk),
        .axis_aresetn  (axis_aresetn),
        .sof_strb      (sof_strb),
        .average_level (average_level),
        .avg_level     (avg_level),
        .sum_keep      (sum_keep),
        .out_en        (out_en)
    );

    pix_sum_stage pix_sum_stage_i (
        .axis_aclk    (axis_aclk),
        .axis_aresetn (axis_aresetn),
        .sum_keep     (sum_keep),
        .img_tdata    (s_axis_img_tdata),
        .img_tvalid   (s_axis_img_tvalid),
        .img_tready   (s_axis_img_tready),
        .img_tlast    (s_axis_img_tlast),
        .img_tuser    (s_axis_img_tuser),
        .avgi_tdata   (s_axis_avgi_tdata),
        .avgi_tvalid  (s_axis_avgi_tvalid),
        .avgi_tready  (s_axis_avgi_tready),
        .sum_o        (sum_s.src)
    );

    sum_fork sum_fork_i (
        .axis_aclk    (axis_aclk),
        .axis_aresetn (axis_aresetn),
        .avg_level    (avg_level),
        .out_en       (out_en),
        .sum_i        (sum_s.snk),
        .avgo_tdata   (m_axis_avgo_tdata),
        .avgo_tvalid  (m_axis_avgo_tvalid),
        .avgo_tready  (m_axis_avgo_tready),
        .avgo_tlast   (m_axis_avgo_tlast),
        .img_tdata    (m_axis_img_tdata),
        .img_tvalid   (m_axis_img_tvalid),
        .img_tready   (m_axis_img_tready),
        .img_tlast    (m_axis_img_tlast),
        .img_tuser    (m_axis_img_tuser)
    );

    // stored sums must stay line aligned with the incoming image
    a_avgi_line_align : assert property (
        @(posedge axis_aclk) disable iff (!axis_aresetn)
        s_axis_img_tvalid && s_axis_img_tready |-> s_axis_avgi_tlast == s_axis_img_tlast
    ) else $error("avgi tlast out of step with image tlast");

endmodule

// File: dv/frame_averager_tb.sv
/*
 * Frame averager testbench.
 * Drives image frames with an averaging buffer memory model behind
 * avgi/avgo and checks sums, scaled image beats and framing bits.
 */

module frame_averager_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import frame_avg_pkg::*;

    localparam int MAX_PIX    = 16;
    localparam int PIX_BEATS  = 2 * 16 + 9 * 16 + 128 * 4 + 4 * 16 + 2 * 12;
    localparam int NUM_FRAMES = 2 + 9 + 128 + 4 + 2;
    localparam int WATCHDOG_CYCLES = PIX_BEATS * 4 + NUM_FRAMES * 8 + 2000;

    logic               axis_aclk;
    logic               axis_aresetn;
    logic [LEVEL_W-1:0] average_level;
    logic               sof_strb;
    logic [IMG_W-1:0]   s_axis_img_tdata;
    logic               s_axis_img_tvalid;
    logic               s_axis_img_tready;
    logic               s_axis_img_tlast;
    logic               s_axis_img_tuser;
    logic [SUM_W-1:0]   s_axis_avgi_tdata;
    logic               s_axis_avgi_tvalid;
    logic               s_axis_avgi_tready;
    logic               s_axis_avgi_tlast;
    logic [SUM_W-1:0]   m_axis_avgo_tdata;
    logic               m_axis_avgo_tvalid;
    logic               m_axis_avgo_tready;
    logic               m_axis_avgo_tlast;
    logic [IMG_W-1:0]   m_axis_img_tdata;
    logic               m_axis_img_tvalid;
    logic               m_axis_img_tready;
    logic               m_axis_img_tlast;
    logic               m_axis_img_tuser;

    logic [31:0]      lfsr = 32'hb57e;
    logic [PIX_W-1:0] pix [MAX_PIX];
    logic             pix_last [MAX_PIX];
    logic [SUM_W-1:0] exp_sum [MAX_PIX];
    logic [SUM_W-1:0] model_sum [MAX_PIX];    // expected stored sums
    logic [SUM_W-1:0] mem [MAX_PIX];          // external sum buffer starts at zero
    logic [SUM_W-1:0] next_mem [MAX_PIX];
    int               m_cnt;
    logic [LEVEL_W-1:0] m_level;
    logic             m_keep;
    logic             m_out_en;

    frame_averager_top frame_averager_top_i (.*);

    always #50 axis_aclk = ~axis_aclk;

    function automatic logic lfsr_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];    // taps 32, 22, 2, 1
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            $display("Fail at %0d ns: %s, got %0h expected %0h", $time, msg, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    // frame control rules applied at each sof_strb
    task automatic model_sof(input logic [LEVEL_W-1:0] new_level);
        if (m_level != 0) begin
            if (m_cnt == 0) begin
                m_out_en = 1'b0;
                m_keep   = 1'b0;
                m_level  = new_level;
                m_cnt    = 1;
            end else begin
                m_keep = 1'b1;
                if (m_cnt == (1 << m_level) - 1) begin
                    m_out_en = 1'b1;
                    m_cnt    = 0;
                end else begin
                    m_out_en = 1'b0;
                    m_cnt    = m_cnt + 1;
                end
            end
        end else begin
            m_level  = new_level;
            m_out_en = 1'b1;
            m_keep   = 1'b0;
            m_cnt    = 0;
        end
    endtask

    task automatic drive_img(input int n);
        for (int i = 0; i < n; i++) begin
            s_axis_img_tdata  = IMG_W'(pix[i]);
            s_axis_img_tlast  = pix_last[i];
            s_axis_img_tuser  = (i == 0);    // start of frame
            s_axis_img_tvalid = 1'b1;
            do @(negedge axis_aclk); while (!s_axis_img_tready);
            @(posedge axis_aclk);
            #1;
        end
        s_axis_img_tvalid = 1'b0;
    endtask

    task automatic drive_avgi(input int n);
        for (int i = 0; i < n; i++) begin
            s_axis_avgi_tdata  = mem[i];    // replay of last frame's avgo
            s_axis_avgi_tlast  = pix_last[i];
            s_axis_avgi_tvalid = 1'b1;
            do @(negedge axis_aclk); while (!s_axis_avgi_tready);
            @(posedge axis_aclk);
            #1;
        end
        s_axis_avgi_tvalid = 1'b0;
    endtask

    task automatic collect_outputs(input int n, input int img_n_exp, input bit bp);
        int avgo_n;
        int img_n;
        avgo_n = 0;
        img_n  = 0;
        while (avgo_n < n || img_n < img_n_exp) begin
            m_axis_avgo_tready = bp ? lfsr_bit() : 1'b1;
            m_axis_img_tready  = bp ? lfsr_bit() : 1'b1;
            @(negedge axis_aclk);    // beat transfers at the next rising edge
            if (m_axis_avgo_tvalid && m_axis_avgo_tready) begin
                check(avgo_n < n, 1, "avgo beat beyond end of frame");
                check(m_axis_avgo_tdata, exp_sum[avgo_n], "avgo sum");
                check(m_axis_avgo_tlast, pix_last[avgo_n], "avgo tlast");
                next_mem[avgo_n] = m_axis_avgo_tdata;
                avgo_n++;
            end
            if (m_axis_img_tvalid && m_axis_img_tready) begin
                check(img_n < img_n_exp, 1, "image beat not expected in this frame");
                check(m_axis_img_tdata, IMG_W'(PIX_W'(exp_sum[img_n] >> m_level)), "image pixel");
                check(m_axis_img_tlast, pix_last[img_n], "image tlast");
                check(m_axis_img_tuser, (img_n == 0), "image tuser");
                img_n++;
            end
            @(posedge axis_aclk);
            #1;
        end
        m_axis_avgo_tready = 1'b1;
        m_axis_img_tready  = 1'b1;
        @(negedge axis_aclk);
        check(m_axis_avgo_tvalid, 0, "avgo valid after frame end");
        check(m_axis_img_tvalid, 0, "image valid after frame end");
        @(posedge axis_aclk);
        #1;
    endtask

    // one frame from an empty pipeline
    task automatic run_frame(input logic [LEVEL_W-1:0] lvl, input bit bp, input int n,
                             input int line_w);
        for (int i = 0; i < n; i++) begin
            pix[i]      = PIX_W'(rand_bits(PIX_W));
            pix_last[i] = (i % line_w == line_w - 1);
        end
        average_level = lvl;
        sof_strb      = 1'b1;
        @(posedge axis_aclk);
        #1;
        sof_strb = 1'b0;
        model_sof(lvl);
        for (int i = 0; i < n; i++) begin
            exp_sum[i]   = (m_keep ? model_sum[i] : '0) + SUM_W'(pix[i]);
            model_sum[i] = exp_sum[i];
        end
        fork
            drive_img(n);
            drive_avgi(n);
            collect_outputs(n, m_out_en ? n : 0, bp);
        join
        for (int i = 0; i < n; i++) begin
            mem[i] = next_mem[i];
        end
    endtask

    task automatic idle_after_reset();
        check(m_axis_img_tvalid, 0, "image valid after reset");
        check(m_axis_avgo_tvalid, 0, "avgo valid after reset");
        check(s_axis_img_tready, 0, "image ready after reset");
        check(s_axis_avgi_tready, 0, "avgi ready after reset");
    endtask

    task automatic pass_through_frames();
        repeat (2) run_frame(3'd0, 1'b0, 16, 4);
    endtask

    task automatic level2_runs();
        repeat (9) run_frame(3'd2, 1'b0, 16, 4);    // switch frame and then two runs
    endtask

    task automatic level7_run();
        repeat (128) run_frame(3'd7, 1'b0, 4, 2);
    endtask

    task automatic backpressure_frames();
        repeat (4) run_frame(3'd1, 1'b1, 16, 4);
    endtask

    task automatic line_framing();
        repeat (2) run_frame(3'd0, 1'b1, 12, 3);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * 100);
        $display("Simulation timed out before all tests finished");
        $display("*** FAILED ***");
        $fatal(1, "timeout");
    end

    initial begin
        axis_aclk          = 1'b0;
        axis_aresetn       = 1'b0;
        average_level      = '0;
        sof_strb           = 1'b0;
        s_axis_img_tdata   = '0;
        s_axis_img_tvalid  = 1'b0;
        s_axis_img_tlast   = 1'b0;
        s_axis_img_tuser   = 1'b0;
        s_axis_avgi_tdata  = '0;
        s_axis_avgi_tvalid = 1'b0;
        s_axis_avgi_tlast  = 1'b0;
        m_axis_avgo_tready = 1'b0;
        m_axis_img_tready  = 1'b0;
        m_cnt    = 0;
        m_level  = '0;
        m_keep   = 1'b0;
        m_out_en = 1'b0;
        for (int i = 0; i < MAX_PIX; i++) begin
            mem[i]       = '0;
            model_sum[i] = '0;
        end
        repeat (4) @(posedge axis_aclk);
        #1;
        axis_aresetn = 1'b1;
        idle_after_reset();
        pass_through_frames();
        level2_runs();
        level7_run();
        backpressure_frames();
        line_framing();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: sources.f
source/frame_avg_pkg.sv
source/pix_stream_if.sv
source/avg_frame_ctrl.sv
source/pix_sum_stage.sv
source/sum_fork.sv
source/frame_averager_top.sv
dv/frame_averager_tb.sv
